//--- mips_params.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// register word and register file size
`define DATA_W      32
`define NUM_REGS    32

// jal/jalr without rd write the return address here
`define LINK_REG    31

// sequencer state codes, EXEC is the one the register file gates on
`define ST_IDLE     2'd0
`define ST_READ     2'd1
`define ST_EXEC     2'd2
`define ST_LOAD_WB  2'd3

`endif

//--- mips_pkg.sv
`include "mips_params.svh"

package mips_pkg;

    typedef enum logic [1:0] {
        st_idle    = `ST_IDLE,    // waiting for an instruction
        st_read    = `ST_READ,    // operands on the read ports
        st_exec    = `ST_EXEC,    // alu and link write-back
        st_load_wb = `ST_LOAD_WB  // load write-back
    } cpu_state_t;

    typedef enum logic [3:0] {
        op_addu,
        op_subu,
        op_and,     // imm zero-extended
        op_or,      // imm zero-extended
        op_xor,     // imm zero-extended
        op_nor,
        op_slt,
        op_sltu,
        op_sll,
        op_srl,
        op_sra,
        op_lui
    } alu_op_t;

    typedef enum logic [2:0] {
        ld_lb,
        ld_lbu,
        ld_lh,
        ld_lhu,
        ld_lw,
        ld_lwl,     // merges into the upper lanes
        ld_lwr      // merges into the lower lanes
    } load_kind_t;

endpackage

//--- regfile.sv
`timescale 1ns/1ns
`include "mips_params.svh"

module regfile import mips_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [4:0]         addr_rs,
    input  logic [4:0]         addr_rt,
    input  logic [4:0]         addr_rd,
    input  cpu_state_t         state,
    input  logic               r_type,
    input  logic               link_to_ra,
    input  logic               wr_alu,
    input  logic               wr_pc,
    input  logic               ld_commit,
    input  logic [`DATA_W-1:0] alu_data,
    input  logic [`DATA_W-1:0] ld_data,
    input  logic [`DATA_W-1:0] link_data,
    input  logic [3:0]         ld_byteen,
    output logic [`DATA_W-1:0] read_data_1,
    output logic [`DATA_W-1:0] read_data_2,
    output logic [`DATA_W-1:0] v0
);

    logic [`DATA_W-1:0] regs [`NUM_REGS];
    logic               wr_en;
    logic [4:0]         wr_addr;
    logic [`DATA_W-1:0] wr_data;
    logic [3:0]         wr_be;
    logic               be_ok;

    assign read_data_1 = (addr_rs == 5'd0) ? '0 : regs[addr_rs];  // r0 reads zero
    assign read_data_2 = (addr_rt == 5'd0) ? '0 : regs[addr_rt];
    assign v0          = regs[2];

    // one write per cycle: alu first, then load, then link
    always_comb begin
        wr_en   = 1'b0;
        wr_addr = addr_rt;
        wr_data = alu_data;
        wr_be   = 4'b1111;
        if (wr_alu && state == st_exec) begin
            wr_en   = 1'b1;
            wr_addr = r_type ? addr_rd : addr_rt;
        end else if (ld_commit) begin
            wr_en   = 1'b1;
            wr_data = ld_data;                              // loads always target rt
            wr_be   = ld_byteen;
        end else if (wr_pc && state == st_exec) begin
            wr_en   = 1'b1;
            wr_addr = link_to_ra ? 5'(`LINK_REG) : addr_rd;
            wr_data = link_data;
        end
    end

    // full word and the lwl/lwr merge patterns only
    always_comb begin
        case (wr_be)
            4'b1111,
            4'b1110, 4'b1100, 4'b1000,
            4'b0111, 4'b0011, 4'b0001: be_ok = 1'b1;
            default:                   be_ok = 1'b0;      // register left as is
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && be_ok && wr_addr != 5'd0) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_be[b]) begin
                    regs[wr_addr][8*b +: 8] <= wr_data[8*b +: 8];  // lane b
                end
            end
        end
    end

endmodule

//--- alu.sv
`timescale 1ns/1ns
`include "mips_params.svh"

module alu import mips_pkg::*; (
    input  logic [`DATA_W-1:0] rs_data,
    input  logic [`DATA_W-1:0] rt_data,
    input  logic [15:0]        imm,
    input  logic [4:0]         shamt,
    input  alu_op_t            alu_op,
    input  logic               r_type,
    output logic [`DATA_W-1:0] result
);

    logic [`DATA_W-1:0] imm_ext;
    logic [`DATA_W-1:0] op_a;
    logic [`DATA_W-1:0] op_b;
    logic               zero_ext;

    // logical immediates are unsigned in mips
    assign zero_ext = (alu_op == op_and) || (alu_op == op_or) || (alu_op == op_xor);

    always_comb begin
        if (zero_ext) begin
            imm_ext = {{(`DATA_W-16){1'b0}}, imm};
        end else begin
            imm_ext = {{(`DATA_W-16){imm[15]}}, imm};
        end
    end

    assign op_a = rs_data;
    assign op_b = r_type ? rt_data : imm_ext;

    always_comb begin
        case (alu_op)
            op_addu: result = op_a + op_b;
            op_subu: result = op_a - op_b;
            op_and:  result = op_a & op_b;
            op_or:   result = op_a | op_b;
            op_xor:  result = op_a ^ op_b;
            op_nor:  result = ~(op_a | op_b);
            op_slt: begin
                result = ($signed(op_a) < $signed(op_b)) ? `DATA_W'(1) : '0;
            end
            op_sltu: begin
                result = (op_a < op_b) ? `DATA_W'(1) : '0;
            end
            op_sll:  result = op_b << shamt;                     // shifts act on operand b
            op_srl:  result = op_b >> shamt;
            op_sra:  result = $unsigned($signed(op_b) >>> shamt);
            op_lui:  result = {imm, 16'h0000};
            default: result = '0;                                // unused op codes
        endcase
    end

endmodule

//--- load_align.sv
`timescale 1ns/1ns
`include "mips_params.svh"

module load_align import mips_pkg::*; (
    input  logic [`DATA_W-1:0] mem_rdata,
    input  logic [1:0]         byte_off,
    input  load_kind_t         load_kind,
    output logic [`DATA_W-1:0] ld_data,
    output logic [3:0]         ld_byteen
);

    logic [7:0]         byte_sel;
    logic [15:0]        half_sel;
    logic [`DATA_W-1:0] lwl_data;
    logic [`DATA_W-1:0] lwr_data;
    logic [3:0]         lwl_be;
    logic [3:0]         lwr_be;

    // little-endian lanes, byte k sits at bits 8k+7..8k
    assign byte_sel = mem_rdata[8*byte_off +: 8];
    assign half_sel = byte_off[1] ? mem_rdata[31:16] : mem_rdata[15:0];  // bit 0 ignored

    // lwl pulls the low bytes of the word up into the top of rt
    assign lwl_data = mem_rdata << (8 * (2'd3 - byte_off));
    // lwr pulls the high bytes down into the bottom of rt
    assign lwr_data = mem_rdata >> (8 * byte_off);

    always_comb begin
        case (byte_off)
            2'd0:    lwl_be = 4'b1000;
            2'd1:    lwl_be = 4'b1100;
            2'd2:    lwl_be = 4'b1110;
            default: lwl_be = 4'b1111;
        endcase
    end

    always_comb begin
        case (byte_off)
            2'd0:    lwr_be = 4'b1111;
            2'd1:    lwr_be = 4'b0111;
            2'd2:    lwr_be = 4'b0011;
            default: lwr_be = 4'b0001;
        endcase
    end

    always_comb begin
        ld_data   = '0;
        ld_byteen = 4'b1111;
        case (load_kind)
            ld_lb:   ld_data = {{(`DATA_W-8){byte_sel[7]}}, byte_sel};
            ld_lbu:  ld_data = {{(`DATA_W-8){1'b0}}, byte_sel};
            ld_lh:   ld_data = {{(`DATA_W-16){half_sel[15]}}, half_sel};
            ld_lhu:  ld_data = {{(`DATA_W-16){1'b0}}, half_sel};
            ld_lw:   ld_data = mem_rdata;
            ld_lwl: begin
                ld_data   = lwl_data;
                ld_byteen = lwl_be;
            end
            ld_lwr: begin
                ld_data   = lwr_data;
                ld_byteen = lwr_be;
            end
            default: ld_byteen = 4'b0000;                        // no write
        endcase
    end

endmodule

//--- cycle_control.sv
`timescale 1ns/1ns
`include "mips_params.svh"

module cycle_control import mips_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               instr_valid,
    input  logic [4:0]         addr_rs,
    input  logic [4:0]         addr_rt,
    input  logic [4:0]         addr_rd,
    input  logic [4:0]         shamt,
    input  logic [15:0]        imm,
    input  alu_op_t            alu_op,
    input  logic               r_type,
    input  logic               is_load,
    input  load_kind_t         load_kind,
    input  logic               is_link,
    input  logic               link_to_ra,
    input  logic [`DATA_W-1:0] pc,
    input  logic [`DATA_W-1:0] mem_rdata,
    output logic               ready,
    output cpu_state_t         state,
    output logic [4:0]         addr_rs_q,
    output logic [4:0]         addr_rt_q,
    output logic [4:0]         addr_rd_q,
    output logic [4:0]         shamt_q,
    output logic [15:0]        imm_q,
    output alu_op_t            alu_op_q,
    output logic               r_type_q,
    output load_kind_t         load_kind_q,
    output logic               link_to_ra_q,
    output logic [`DATA_W-1:0] mem_rdata_q,
    output logic               wr_alu,
    output logic               wr_pc,
    output logic               ld_commit,
    output logic [`DATA_W-1:0] link_data
);

    logic               accept;
    logic               is_load_q;
    logic [`DATA_W-1:0] pc_q;

    assign ready     = (state == st_idle);
    assign accept    = instr_valid && ready;       // strobe while busy is dropped
    assign link_data = pc_q + `DATA_W'(8);         // return past the delay slot

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_idle;
            is_load_q <= 1'b0;
            wr_alu    <= 1'b0;
            wr_pc     <= 1'b0;
            ld_commit <= 1'b0;
        end else begin
            ld_commit <= 1'b0;
            case (state)
                st_idle: begin
                    if (accept) begin
                        state     <= st_read;
                        is_load_q <= is_load;
                        wr_alu    <= !is_load && !is_link;   // held until back in idle
                        wr_pc     <= is_link && !is_load;
                    end
                end
                st_read: state <= st_exec;
                st_exec: begin
                    if (is_load_q) begin
                        state     <= st_load_wb;
                        ld_commit <= 1'b1;                   // high for load_wb only
                    end else begin
                        state  <= st_idle;
                        wr_alu <= 1'b0;
                        wr_pc  <= 1'b0;
                    end
                end
                default: state <= st_idle;                   // load_wb
            endcase
        end
    end

    // instruction fields, held for the whole instruction
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_rs_q    <= addr_rs;
            addr_rt_q    <= addr_rt;
            addr_rd_q    <= addr_rd;
            shamt_q      <= shamt;
            imm_q        <= imm;
            alu_op_q     <= is_load ? op_addu : alu_op;  // load address is rs + simm
            r_type_q     <= r_type && !is_load;
            load_kind_q  <= load_kind;
            link_to_ra_q <= link_to_ra;
            pc_q         <= pc;
            mem_rdata_q  <= mem_rdata;
        end
    end

endmodule

//--- exec_datapath.sv
`timescale 1ns/1ns
`include "mips_params.svh"

module exec_datapath import mips_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               instr_valid,
    input  logic [4:0]         addr_rs,
    input  logic [4:0]         addr_rt,
    input  logic [4:0]         addr_rd,
    input  logic [4:0]         shamt,
    input  logic [15:0]        imm,
    input  alu_op_t            alu_op,
    input  logic               r_type,
    input  logic               is_load,
    input  load_kind_t         load_kind,
    input  logic               is_link,
    input  logic               link_to_ra,
    input  logic [`DATA_W-1:0] pc,
    input  logic [`DATA_W-1:0] mem_rdata,
    output logic               ready,
    output logic [`DATA_W-1:0] rs_value,
    output logic [`DATA_W-1:0] rt_value,
    output logic [`DATA_W-1:0] alu_result,
    output logic [`DATA_W-1:0] v0
);

    cpu_state_t         state;
    logic [4:0]         addr_rs_q;
    logic [4:0]         addr_rt_q;
    logic [4:0]         addr_rd_q;
    logic [4:0]         shamt_q;
    logic [15:0]        imm_q;
    alu_op_t            alu_op_q;
    logic               r_type_q;
    load_kind_t         load_kind_q;
    logic               link_to_ra_q;
    logic [`DATA_W-1:0] mem_rdata_q;
    logic               wr_alu;
    logic               wr_pc;
    logic               ld_commit;
    logic [`DATA_W-1:0] link_data;
    logic [`DATA_W-1:0] ld_data;
    logic [3:0]         ld_byteen;

    cycle_control u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .addr_rs      (addr_rs),
        .addr_rt      (addr_rt),
        .addr_rd      (addr_rd),
        .shamt        (shamt),
        .imm          (imm),
        .alu_op       (alu_op),
        .r_type       (r_type),
        .is_load      (is_load),
        .load_kind    (load_kind),
        .is_link      (is_link),
        .link_to_ra   (link_to_ra),
        .pc           (pc),
        .mem_rdata    (mem_rdata),
        .ready        (ready),
        .state        (state),
        .addr_rs_q    (addr_rs_q),
        .addr_rt_q    (addr_rt_q),
        .addr_rd_q    (addr_rd_q),
        .shamt_q      (shamt_q),
        .imm_q        (imm_q),
        .alu_op_q     (alu_op_q),
        .r_type_q     (r_type_q),
        .load_kind_q  (load_kind_q),
        .link_to_ra_q (link_to_ra_q),
        .mem_rdata_q  (mem_rdata_q),
        .wr_alu       (wr_alu),
        .wr_pc        (wr_pc),
        .ld_commit    (ld_commit),
        .link_data    (link_data)
    );

    regfile u_regs (
        .clk         (clk),
        .rst         (rst),
        .addr_rs     (addr_rs_q),
        .addr_rt     (addr_rt_q),
        .addr_rd     (addr_rd_q),
        .state       (state),
        .r_type      (r_type_q),
        .link_to_ra  (link_to_ra_q),
        .wr_alu      (wr_alu),
        .wr_pc       (wr_pc),
        .ld_commit   (ld_commit),
        .alu_data    (alu_result),
        .ld_data     (ld_data),
        .link_data   (link_data),
        .ld_byteen   (ld_byteen),
        .read_data_1 (rs_value),
        .read_data_2 (rt_value),
        .v0          (v0)
    );

    alu u_alu (
        .rs_data (rs_value),
        .rt_data (rt_value),
        .imm     (imm_q),
        .shamt   (shamt_q),
        .alu_op  (alu_op_q),
        .r_type  (r_type_q),
        .result  (alu_result)
    );

    load_align u_ld (
        .mem_rdata (mem_rdata_q),
        .byte_off  (alu_result[1:0]),   // low bits of rs + simm
        .load_kind (load_kind_q),
        .ld_data   (ld_data),
        .ld_byteen (ld_byteen)
    );

endmodule

//--- exec_checker.sv
`timescale 1ns/1ns

module exec_checker import mips_pkg::*; (
    input logic       clk,
    input logic       rst,
    input logic       instr_valid,
    input logic       ready,
    input logic       is_load,
    input cpu_state_t state,
    input logic       wr_alu,
    input logic       wr_pc,
    input logic       ld_commit
);

    int   short_fails;
    int   long_fails;
    int   commit_fails;
    int   excl_fails;
    int   reset_fails;
    int   fail_total;
    logic accept;

    assign accept     = instr_valid && ready;
    assign fail_total = short_fails + long_fails + commit_fails + excl_fails + reset_fails;

    // alu and link instructions are busy for two cycles
    a_short_busy: assert property (@(posedge clk) disable iff (rst)
        accept && !is_load |=> !ready ##1 !ready ##1 ready)
        else begin
            short_fails++;
            $error("ready not low for exactly 2 cycles after an alu or link instruction");
        end

    // loads take one more cycle for the write-back state
    a_long_busy: assert property (@(posedge clk) disable iff (rst)
        accept && is_load |=> !ready ##1 !ready ##1 !ready ##1 ready)
        else begin
            long_fails++;
            $error("ready not low for exactly 3 cycles after a load");
        end

    a_commit_state: assert property (@(posedge clk) disable iff (rst)
        ld_commit |-> state == st_load_wb)
        else begin
            commit_fails++;
            $error("ld_commit high outside the load write-back state");
        end

    a_one_source: assert property (@(posedge clk) disable iff (rst)
        !(wr_alu && wr_pc))
        else begin
            excl_fails++;
            $error("wr_alu and wr_pc high together");
        end

    a_reset_quiet: assert property (@(posedge clk)
        rst |=> !wr_alu && !wr_pc && !ld_commit)
        else begin
            reset_fails++;
            $error("write enables not low in the cycle after reset");
        end

endmodule

bind cycle_control exec_checker u_checker (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .ready       (ready),
    .is_load     (is_load),
    .state       (state),
    .wr_alu      (wr_alu),
    .wr_pc       (wr_pc),
    .ld_commit   (ld_commit)
);

//--- tb_exec_datapath.sv
`timescale 1ns/1ns
`include "mips_params.svh"

module tb_exec_datapath import mips_pkg::*; ();

    localparam int N_ALU   = 200;
    localparam int N_LOAD  = 150;
    localparam int N_LINK  = 40;
    localparam int N_SHORT = `NUM_REGS + N_ALU + 5 + N_LOAD + 2 * N_LINK;  // 3-cycle instructions
    localparam int N_LONG  = N_LOAD + 1;                                   // 4-cycle loads
    localparam int CYCLE_LIMIT = 4 * (3 * N_SHORT + 4 * N_LONG) + 50;

    logic               clk;
    logic               rst;
    logic               instr_valid;
    logic [4:0]         addr_rs;
    logic [4:0]         addr_rt;
    logic [4:0]         addr_rd;
    logic [4:0]         shamt;
    logic [15:0]        imm;
    alu_op_t            alu_op;
    logic               r_type;
    logic               is_load;
    load_kind_t         load_kind;
    logic               is_link;
    logic               link_to_ra;
    logic [`DATA_W-1:0] pc;
    logic [`DATA_W-1:0] mem_rdata;
    logic               ready;
    logic [`DATA_W-1:0] rs_value;
    logic [`DATA_W-1:0] rt_value;
    logic [`DATA_W-1:0] alu_result;
    logic [`DATA_W-1:0] v0;

    logic [31:0] model [32];        // expected register contents
    integer      seed;
    int          checks;
    int          errors;
    int          start_checks;
    int          start_errors;
    int          cycle_count;
    string       test_name;

    // next instruction to issue
    logic [4:0]  cur_rs;
    logic [4:0]  cur_rt;
    logic [4:0]  cur_rd;
    logic [4:0]  cur_sh;
    logic [15:0] cur_imm;
    alu_op_t     cur_op;
    logic        cur_rtype;
    logic        cur_load;
    load_kind_t  cur_kind;
    logic        cur_link;
    logic        cur_ra;
    logic [31:0] cur_pc;
    logic [31:0] cur_word;

    exec_datapath u_dut (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .addr_rs     (addr_rs),
        .addr_rt     (addr_rt),
        .addr_rd     (addr_rd),
        .shamt       (shamt),
        .imm         (imm),
        .alu_op      (alu_op),
        .r_type      (r_type),
        .is_load     (is_load),
        .load_kind   (load_kind),
        .is_link     (is_link),
        .link_to_ra  (link_to_ra),
        .pc          (pc),
        .mem_rdata   (mem_rdata),
        .ready       (ready),
        .rs_value    (rs_value),
        .rt_value    (rt_value),
        .alu_result  (alu_result),
        .v0          (v0)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == CYCLE_LIMIT) begin
            $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] rand_word();
        rand_word = $random(seed);
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("error %s %s: expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic begin_test(input string name);
        test_name    = name;
        start_checks = checks;
        start_errors = errors;
    endtask

    task automatic end_test();
        $display("%s: %0d checks, %0d errors", test_name, checks - start_checks,
                 errors - start_errors);
    endtask

    task automatic write_model(input logic [4:0] r, input logic [31:0] data);
        if (r != 5'd0) begin
            model[r] = data;                                 // r0 stays zero
        end
    endtask

    function automatic logic [31:0] expect_alu(input alu_op_t op, input logic rform,
                                               input logic [31:0] a, input logic [31:0] rt_val,
                                               input logic [15:0] im, input logic [4:0] sh);
        logic [31:0] b;
        if (op == op_and || op == op_or || op == op_xor) begin
            b = {16'h0000, im};
        end else begin
            b = {{16{im[15]}}, im};
        end
        if (rform) begin
            b = rt_val;
        end
        case (op)
            op_addu: return a + b;
            op_subu: return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_nor:  return ~(a | b);
            op_slt:  return {31'b0, $signed(a) < $signed(b)};
            op_sltu: return {31'b0, a < b};
            op_sll:  return b << sh;
            op_srl:  return b >> sh;
            op_sra:  return 32'($signed(b) >>> sh);
            op_lui:  return {im, 16'h0000};
            default: return 32'h0;
        endcase
    endfunction

    // new rt contents after a load at byte offset k
    function automatic logic [31:0] merge_load(input load_kind_t kind, input logic [1:0] k,
                                               input logic [31:0] word, input logic [31:0] old);
        logic [7:0]  b8;
        logic [15:0] h16;
        logic [31:0] shifted;
        logic [31:0] res;
        b8  = word[8*k +: 8];
        h16 = k[1] ? word[31:16] : word[15:0];
        res = old;
        case (kind)
            ld_lb:  res = {{24{b8[7]}}, b8};
            ld_lbu: res = {24'h0, b8};
            ld_lh:  res = {{16{h16[15]}}, h16};
            ld_lhu: res = {16'h0, h16};
            ld_lw:  res = word;
            ld_lwl: begin
                shifted = word << (8 * (3 - k));
                for (int i = 0; i <= int'(k); i++) begin
                    res[8*(3-i) +: 8] = shifted[8*(3-i) +: 8];   // top k+1 lanes
                end
            end
            ld_lwr: begin
                shifted = word >> (8 * k);
                for (int i = 0; i < 4 - int'(k); i++) begin
                    res[8*i +: 8] = shifted[8*i +: 8];           // bottom 4-k lanes
                end
            end
            default: res = old;
        endcase
        return res;
    endfunction

    // issue cur_* and follow it to ready, checking READ values, latency and v0
    task automatic run_instr();
        logic [31:0] a_val;
        logic [31:0] b_val;
        logic [31:0] exp_res;
        logic [31:0] addr;
        int          lat;
        int          exp_lat;
        a_val   = model[cur_rs];
        b_val   = model[cur_rt];
        exp_res = expect_alu(cur_op, cur_rtype, a_val, b_val, cur_imm, cur_sh);
        addr    = a_val + {{16{cur_imm[15]}}, cur_imm};
        @(posedge clk);
        instr_valid <= 1'b1;
        addr_rs     <= cur_rs;
        addr_rt     <= cur_rt;
        addr_rd     <= cur_rd;
        shamt       <= cur_sh;
        imm         <= cur_imm;
        alu_op      <= cur_op;
        r_type      <= cur_rtype;
        is_load     <= cur_load;
        load_kind   <= cur_kind;
        is_link     <= cur_link;
        link_to_ra  <= cur_ra;
        pc          <= cur_pc;
        mem_rdata   <= cur_word;
        @(posedge clk);                                      // accepted here
        instr_valid <= 1'b0;
        lat = 1;
        @(negedge clk);
        check_value("rs_value", a_val, rs_value);
        check_value("rt_value", b_val, rt_value);
        if (cur_load) begin
            check_value("load address", addr, alu_result);
        end else if (!cur_link) begin
            check_value("alu_result", exp_res, alu_result);
        end
        while (!ready) begin
            @(posedge clk);
            lat++;
            @(negedge clk);
        end
        exp_lat = cur_load ? 4 : 3;
        check_value("latency", 32'(exp_lat), 32'(lat));
        if (cur_load) begin
            write_model(cur_rt, merge_load(cur_kind, addr[1:0], cur_word, model[cur_rt]));
        end else if (cur_link) begin
            write_model(cur_ra ? 5'(`LINK_REG) : cur_rd, cur_pc + 32'd8);
        end else begin
            write_model(cur_rtype ? cur_rd : cur_rt, exp_res);
        end
        check_value("v0", model[2], v0);
    endtask

    task automatic set_random();
        cur_rs    = 5'(rand_word());
        cur_rt    = 5'(rand_word());
        cur_rd    = 5'(rand_word());
        cur_sh    = 5'(rand_word());
        cur_imm   = 16'(rand_word());
        cur_op    = alu_op_t'(4'(rand_word() % 12));
        cur_rtype = rand_word() % 2 == 1;
        cur_load  = 1'b0;
        cur_kind  = load_kind_t'(3'(rand_word() % 7));
        cur_link  = 1'b0;
        cur_ra    = rand_word() % 2 == 1;
        cur_pc    = rand_word();
        cur_word  = rand_word();
    endtask

    // read r on both ports through an or whose write to r0 is dropped
    task automatic probe_reg(input logic [4:0] r);
        set_random();
        cur_rs    = r;
        cur_rt    = r;
        cur_rd    = 5'd0;
        cur_op    = op_or;
        cur_rtype = 1'b1;
        run_instr();
    endtask

    initial begin
        logic [4:0] target;
        int         off;
        seed        = 39;
        checks      = 0;
        errors      = 0;
        cycle_count = 0;
        rst         = 1'b1;
        instr_valid = 1'b0;
        addr_rs     = '0;
        addr_rt     = '0;
        addr_rd     = '0;
        shamt       = '0;
        imm         = '0;
        alu_op      = op_addu;
        r_type      = 1'b0;
        is_load     = 1'b0;
        load_kind   = ld_lw;
        is_link     = 1'b0;
        link_to_ra  = 1'b0;
        pc          = '0;
        mem_rdata   = '0;
        for (int r = 0; r < 32; r++) begin
            model[r] = 32'h0;
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        begin_test("reset_clear");
        check_value("v0", 32'h0, v0);
        for (int r = 0; r < `NUM_REGS; r++) begin
            probe_reg(5'(r));
        end
        end_test();

        begin_test("alu_writeback");
        for (int i = 0; i < N_ALU; i++) begin
            set_random();
            run_instr();
        end
        end_test();

        begin_test("zero_reg");
        set_random();
        cur_op    = op_addu;
        cur_rtype = 1'b1;
        cur_rd    = 5'd0;
        run_instr();
        probe_reg(5'd0);
        set_random();
        cur_load  = 1'b1;
        cur_kind  = ld_lw;
        cur_rt    = 5'd0;
        run_instr();
        probe_reg(5'd0);
        set_random();
        cur_link  = 1'b1;
        cur_ra    = 1'b0;
        cur_rd    = 5'd0;
        run_instr();
        probe_reg(5'd0);
        end_test();

        begin_test("load_lanes");
        for (int i = 0; i < N_LOAD; i++) begin
            set_random();
            cur_load     = 1'b1;
            cur_kind     = load_kind_t'(3'(i % 7));
            off          = (i / 7) % 4;                      // walk every kind and offset
            cur_imm[1:0] = 2'(off) - model[cur_rs][1:0];
            target       = cur_rt;
            run_instr();
            probe_reg(target);
        end
        end_test();

        begin_test("link_write");
        for (int i = 0; i < N_LINK; i++) begin
            set_random();
            cur_link = 1'b1;
            target   = cur_ra ? 5'(`LINK_REG) : cur_rd;
            run_instr();
            probe_reg(target);
        end
        end_test();

        $display("total: %0d checks, %0d errors, %0d assertion failures", checks, errors,
                 u_dut.u_ctrl.u_checker.fail_total);
        if (errors == 0 && u_dut.u_ctrl.u_checker.fail_total == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+.
mips_pkg.sv
regfile.sv
alu.sv
load_align.sv
cycle_control.sv
exec_datapath.sv
exec_checker.sv
tb_exec_datapath.sv

//--- run_sim.sh
#!/bin/sh
# build and run the exec_datapath testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f verilog.f \
    --top-module tb_exec_datapath \
    -o sim_exec

# let assertion errors accumulate so the run reaches its summary
./obj_dir/sim_exec +verilator+error+limit+1000 | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
